// File: run.sh
#!/usr/bin/env bash
# builds the aluCore testbench with Verilator and runs it.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
	--top-module aluCoreTb \
	-f sim.f \
	-Mdir obj_dir \
	-o simAluCore; then
	echo "verilator build failed"
	exit 1
fi

# assertion errors are counted by the checker, the testbench stops the run.
if ! ./obj_dir/simAluCore +verilator+error+limit+1000; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: sim.f
verilog/aluCorePkg.sv
verilog/phaseSequencer.sv
verilog/aluGroupDecoder.sv
verilog/aluExecute.sv
verilog/registerFile.sv
verilog/aluCore.sv
testbench/aluCore_checker.sv
testbench/aluCoreTb.sv

// File: testbench/aluCoreTb.sv
module aluCoreTb;

	localparam int ResetCycles = 10;
	localparam int WaitLimit   = 20;     // cycles allowed for any one wait.
	localparam int RandomCount = 300;

	logic                CLK;
	logic                reset;
	logic [15:0]         instr;
	logic                instrStrobe;
	logic                ready;
	logic                commitValid;
	aluCorePkg::commit_t commitInfo;
	logic [31:0]         rngState;
	bit                  endReported = 1'b0;    // a result line was printed.

	aluCore DUT (
		.CLK         (CLK),
		.reset       (reset),
		.instr       (instr),
		.instrStrobe (instrStrobe),
		.ready       (ready),
		.commitValid (commitValid),
		.commitInfo  (commitInfo)
	);

	bind aluCore aluCoreChecker shadowCheck (
		.CLK         (CLK),
		.reset       (reset),
		.instr       (instr),
		.instrStrobe (instrStrobe),
		.ready       (ready),
		.commitValid (commitValid),
		.commitInfo  (commitInfo)
	);

	initial begin : clockGen
		CLK = 1'b0;
		forever #2 CLK = ~CLK;    // period 4.
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// gpf, aluf, argf, arga, argb.
	function automatic logic [15:0] makeInstr(input logic [1:0] g, input logic [3:0] op,
			input logic [1:0] mode, input logic [3:0] a, input logic [3:0] b);
		return {g, op, mode, a, b};
	endfunction

	task automatic stopWithFailure(input string reason);
		endReported = 1'b1;
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	////////////////////////////////////////////////////////////
	// one instruction: wait ready, strobe, wait commit
	////////////////////////////////////////////////////////////
	task automatic sendInstr(input logic [15:0] word, input logic stray, input logic [15:0] junk);
		int n;
		n = 0;
		while (!ready && n < WaitLimit) begin
			@(negedge CLK);
			n++;
		end
		if (!ready) begin
			stopWithFailure("timed out waiting for ready before a strobe");
		end else begin
			instr       = word;
			instrStrobe = 1'b1;
			@(negedge CLK);           // accepted on the edge in between.
			instr       = junk;
			instrStrobe = stray;      // ignored while ready is low.
			@(negedge CLK);
			instrStrobe = 1'b0;
			n = 0;
			while (!commitValid && n < WaitLimit) begin
				@(negedge CLK);
				n++;
			end
			if (!commitValid) begin
				stopWithFailure("timed out waiting for commitValid after a strobe");
			end
		end
	endtask

	// assertion failures end the run at the next falling edge.
	initial begin : assertionWatch
		forever begin
			@(negedge CLK);
			if (DUT.shadowCheck.failCount != 0) begin
				stopWithFailure("an assertion in the checker failed");
			end
		end
	end

	initial begin : stimulus
		logic [15:0] word;
		reset       = 1'b1;
		instr       = 16'h0000;
		instrStrobe = 1'b0;
		rngState    = 32'd93;
		repeat (ResetCycles) @(negedge CLK);
		reset = 1'b0;
		// preload every register, ra and rb included.
		for (int i = 0; i < aluCorePkg::RegCount; i++) begin
			rngState = xorshift32(rngState);
			sendInstr(makeInstr(aluCorePkg::Group3, aluCorePkg::OpMov, aluCorePkg::ModeRegU4,
				i[3:0], rngState[3:0]), 1'b0, 16'h0000);
		end
		rngState = xorshift32(rngState);
		sendInstr(makeInstr(aluCorePkg::Group3, aluCorePkg::OpMov, aluCorePkg::ModeRegbU8,
			rngState[7:4], rngState[3:0]), 1'b0, 16'h0000);
		sendInstr(makeInstr(aluCorePkg::Group3, aluCorePkg::OpMov, aluCorePkg::ModeRegaU8Rb,
			rngState[15:12], rngState[11:8]), 1'b0, 16'h0000);
		for (int i = 0; i < RandomCount; i++) begin
			rngState = xorshift32(rngState);
			word     = rngState[15:0];
			if (i < 64) begin
				word = makeInstr(aluCorePkg::Group3, i[3:0], i[5:4], word[7:4], word[3:0]);
			end else if (i < 67) begin
				word[aluCorePkg::GroupPos +: 2] = i[1:0];    // groups 0 to 2.
			end else if (rngState[17:16] != 2'b00) begin
				word[aluCorePkg::GroupPos +: 2] = aluCorePkg::Group3;    // mostly alu.
			end
			sendInstr(word, rngState[20], rngState[31:16]);
		end
		@(negedge CLK);
		if (DUT.shadowCheck.failCount != 0) begin
			stopWithFailure("the checker reported assertion failures");
		end else begin
			endReported = 1'b1;
			$display("Result: PASSED");
			$finish;
		end
	end

	final begin
		if (!endReported) begin
			$display("Result: FAILED");
			$fatal(1, "simulation ended before the stimulus completed");
		end
	end

endmodule

// File: testbench/aluCore_checker.sv
module aluCoreChecker (
	input logic                CLK,
	input logic                reset,
	input logic [15:0]         instr,
	input logic                instrStrobe,
	input logic                ready,
	input logic                commitValid,
	input aluCorePkg::commit_t commitInfo
);

	logic [15:0]        shadowRegs [aluCorePkg::RegCount];
	aluCorePkg::flags_t shadowFlags;
	logic               expWritten;    // expected commit set on accept.
	logic [3:0]         expIndex;
	logic [15:0]        expValue;
	aluCorePkg::flags_t expFlags;
	logic               accept;
	int                 failCount = 0;    // read by the testbench.

	assign accept = ready && instrStrobe && !reset;

	// reference alu returning {result, carry, overflow}.
	function automatic logic [17:0] refAlu(input logic [3:0] op, input logic [15:0] a,
			input logic [15:0] b, input logic cin);
		int          u;    // unsigned view.
		int          s;    // signed view.
		int          ci;
		logic [15:0] r;
		logic        c;
		logic        v;
		ci = (op == aluCorePkg::OpAdc || op == aluCorePkg::OpSbc) ? int'(cin) : 0;
		r  = b;
		c  = cin;    // logic ops keep old carry.
		v  = 1'b0;
		case (op)
			aluCorePkg::OpAdd, aluCorePkg::OpAdc: begin
				u = int'(a) + int'(b) + ci;
				s = int'($signed(a)) + int'($signed(b)) + ci;
				r = u[15:0];
				c = (u > 65535);
				v = (s > 32767) || (s < -32768);    // out of signed range.
			end
			aluCorePkg::OpSub, aluCorePkg::OpSbc, aluCorePkg::OpCmp: begin
				u = int'(a) - int'(b) - ci;
				s = int'($signed(a)) - int'($signed(b)) - ci;
				r = u[15:0];
				c = (u < 0);    // borrow.
				v = (s > 32767) || (s < -32768);
			end
			aluCorePkg::OpNeg: begin
				u = -int'(b);
				s = -int'($signed(b));
				r = u[15:0];
				c = (u < 0);
				v = (s > 32767);    // only -32768 overflows.
			end
			aluCorePkg::OpAnd: r = a & b;
			aluCorePkg::OpOr:  r = a | b;
			aluCorePkg::OpXor: r = a ^ b;
			aluCorePkg::OpNot: r = ~b;
			aluCorePkg::OpShl: begin
				r = a << 1;
				c = a[15];
				v = r[15] ^ a[15];    // sign flipped.
			end
			aluCorePkg::OpShr: begin
				r = a >> 1;
				c = a[0];
			end
			aluCorePkg::OpAsr: begin
				r = $signed(a) >>> 1;
				c = a[0];
			end
			aluCorePkg::OpRol: begin
				r = (a << 1) | (a >> 15);
				c = a[15];
			end
			aluCorePkg::OpRor: begin
				r = (a >> 1) | (a << 15);
				c = a[0];
			end
			default: r = b;    // mov.
		endcase
		return {r, c, v};
	endfunction

	////////////////////////////////////////////////////////////
	// shadow model stepped once per accepted instruction
	////////////////////////////////////////////////////////////
	always @(posedge CLK) begin : shadowUpdate
		logic               isAlu;
		logic [3:0]         op;
		logic [3:0]         argA;
		logic [3:0]         argB;
		logic [3:0]         regA;
		logic [15:0]        b;
		logic [17:0]        out;
		aluCorePkg::flags_t nf;
		isAlu = (instr[aluCorePkg::GroupPos +: 2] == aluCorePkg::Group3);
		op    = instr[aluCorePkg::AluOpPos +: 4];
		argA  = instr[aluCorePkg::ArgAPos +: 4];
		argB  = instr[aluCorePkg::ArgBPos +: 4];
		regA  = argA;
		case (instr[aluCorePkg::ArgfPos +: 2])
			aluCorePkg::ModeRegReg: b = shadowRegs[argB];
			aluCorePkg::ModeRegU4:  b = {12'h000, argB};
			aluCorePkg::ModeRegbU8: begin
				regA = aluCorePkg::RegRb;
				b    = {8'h00, argA, argB};
			end
			default: begin
				regA = aluCorePkg::RegRa;
				b    = shadowRegs[aluCorePkg::RegRb] + {8'h00, argA, argB};
			end
		endcase
		out = refAlu(op, shadowRegs[regA], b, shadowFlags.c);
		nf  = shadowFlags;
		if (isAlu && op != aluCorePkg::OpMov) begin
			nf.z = (out[17:2] == 16'h0000);
			nf.n = out[17];
			nf.c = out[1];
			nf.v = out[0];
		end
		if (reset) begin
			for (int i = 0; i < aluCorePkg::RegCount; i++) begin
				shadowRegs[i] <= '0;
			end
			shadowFlags <= '0;
			expWritten  <= 1'b0;
		end else if (accept) begin
			expWritten  <= isAlu && op != aluCorePkg::OpCmp;
			expIndex    <= regA;
			expValue    <= out[17:2];
			expFlags    <= nf;
			shadowFlags <= nf;
			if (isAlu && op != aluCorePkg::OpCmp) begin
				shadowRegs[regA] <= out[17:2];    // no-op groups leave regs alone.
			end
		end
	end

	////////////////////////////////////////////////////////////
	// assertions
	////////////////////////////////////////////////////////////
	resetState: assert property (@(posedge CLK)
		reset |=> ready && !commitValid && commitInfo.flags == '0)
		else begin
			failCount++;
			$error("[FAIL] %0t ready/commitValid/commitInfo.flags expected 1/0/0 got %b/%b/%h",
				$time, $sampled(ready), $sampled(commitValid), $sampled(commitInfo.flags));
		end

	commitTiming: assert property (@(posedge CLK) disable iff (reset)
		commitValid == $past(accept, 3))
		else begin
			failCount++;
			$error("[FAIL] %0t commitValid expected %b got %b",
				$time, $sampled($past(accept, 3)), $sampled(commitValid));
		end

	commitPulse: assert property (@(posedge CLK) disable iff (reset)
		commitValid |=> !commitValid)
		else begin
			failCount++;
			$error("[FAIL] %0t commitValid expected 0 got 1", $time);
		end

	readyLow: assert property (@(posedge CLK) disable iff (reset)
		($past(accept, 1) || $past(accept, 2) || $past(accept, 3)) |-> !ready)
		else begin
			failCount++;
			$error("[FAIL] %0t ready expected 0 got %b", $time, $sampled(ready));
		end

	readyBack: assert property (@(posedge CLK) disable iff (reset)
		$past(accept, 4) |-> ready)
		else begin
			failCount++;
			$error("[FAIL] %0t ready expected 1 got %b", $time, $sampled(ready));
		end

	writtenMatch: assert property (@(posedge CLK) disable iff (reset)
		commitValid |-> commitInfo.written == expWritten)
		else begin
			failCount++;
			$error("[FAIL] %0t commitInfo.written expected %b got %b",
				$time, $sampled(expWritten), $sampled(commitInfo.written));
		end

	indexMatch: assert property (@(posedge CLK) disable iff (reset)
		commitValid && expWritten |-> commitInfo.regIndex == expIndex)
		else begin
			failCount++;
			$error("[FAIL] %0t commitInfo.regIndex expected %0d got %0d",
				$time, $sampled(expIndex), $sampled(commitInfo.regIndex));
		end

	valueMatch: assert property (@(posedge CLK) disable iff (reset)
		commitValid && expWritten |-> commitInfo.value == expValue)
		else begin
			failCount++;
			$error("[FAIL] %0t commitInfo.value expected %h got %h",
				$time, $sampled(expValue), $sampled(commitInfo.value));
		end

	flagsMatch: assert property (@(posedge CLK) disable iff (reset)
		commitValid |-> commitInfo.flags == expFlags)
		else begin
			failCount++;
			$error("[FAIL] %0t commitInfo.flags expected %h got %h",
				$time, $sampled(expFlags), $sampled(commitInfo.flags));
		end

endmodule

// File: verilog/aluCore.sv
module aluCore (
	input  logic                CLK,
	input  logic                reset,
	input  logic [15:0]         instr,
	input  logic                instrStrobe,
	output logic                ready,
	output logic                commitValid,
	output aluCorePkg::commit_t commitInfo
);

	logic                    decodePhase;
	logic                    executePhase;
	logic                    commitPhase;
	logic [15:0]             instrLatched;
	logic                    readA;
	logic                    readB;
	aluCorePkg::decodeCtrl_t ctrl;
	logic [15:0]             opA;
	logic [15:0]             opB;
	logic [15:0]             result;
	aluCorePkg::flags_t      flags;

	////////////////////////////////////////////////////////////
	// phase control and decode
	////////////////////////////////////////////////////////////
	phaseSequencer sequencer (
		.CLK          (CLK),
		.reset        (reset),
		.instr        (instr),
		.instrStrobe  (instrStrobe),
		.ready        (ready),
		.fetch        (),             // same level as ready.
		.decode       (decodePhase),
		.execute      (executePhase),
		.commit       (commitPhase),
		.instrLatched (instrLatched)
	);

	aluGroupDecoder decoder (
		.CLK          (CLK),
		.reset        (reset),
		.instrLatched (instrLatched),
		.decode       (decodePhase),
		.execute      (executePhase),
		.commit       (commitPhase),
		.readA        (readA),
		.readB        (readB),
		.ctrl         (ctrl)
	);

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////
	registerFile regFile (
		.CLK     (CLK),
		.reset   (reset),
		.decode  (decodePhase),
		.commit  (commitPhase),
		.readA   (readA),
		.readB   (readB),
		.ctrl    (ctrl),
		.result  (result),
		.opA     (opA),
		.opB     (opB)
	);

	aluExecute execUnit (
		.CLK     (CLK),
		.reset   (reset),
		.execute (executePhase),
		.ctrl    (ctrl),
		.opA     (opA),
		.opB     (opB),
		.result  (result),
		.flags   (flags)
	);

	// one pulse per instruction, the commit phase.
	assign commitValid          = commitPhase;
	assign commitInfo.written   = ctrl.writeA;
	assign commitInfo.regIndex  = ctrl.regAAddr;
	assign commitInfo.value     = result;
	assign commitInfo.flags     = flags;

endmodule

// File: verilog/aluCorePkg.sv
package aluCorePkg;

	////////////////////////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////////////////////////
	//  15 14 | 13 .. 10 | 9 8  | 7 .. 4 | 3 .. 0
	//  GPF   | ALUF     | ARGF | ARGA   | ARGB
	localparam int GroupPos = 14;    // gpf, 2 bits.
	localparam int AluOpPos = 10;    // aluf, 4 bits.
	localparam int ArgfPos  = 8;     // argf, 2 bits.
	localparam int ArgAPos  = 4;     // arga, 4 bits.
	localparam int ArgBPos  = 0;     // argb, 4 bits.

	localparam int RegCount = 16;    // register file depth.

	localparam logic [1:0] Group3 = 2'd3;    // alu group.

	// argument modes.
	localparam logic [1:0] ModeRegReg   = 2'd0;    // alu ra, rb.
	localparam logic [1:0] ModeRegU4    = 2'd1;    // alu ra, u4.
	localparam logic [1:0] ModeRegbU8   = 2'd2;    // alu RB, u8.
	localparam logic [1:0] ModeRegaU8Rb = 2'd3;    // alu RA, u8 + RB.

	////////////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////////////
	localparam logic [3:0] OpMov = 4'd0;
	localparam logic [3:0] OpAdd = 4'd1;
	localparam logic [3:0] OpAdc = 4'd2;     // add with stored carry.
	localparam logic [3:0] OpSub = 4'd3;
	localparam logic [3:0] OpSbc = 4'd4;     // subtract with stored borrow.
	localparam logic [3:0] OpAnd = 4'd5;
	localparam logic [3:0] OpOr  = 4'd6;
	localparam logic [3:0] OpXor = 4'd7;
	localparam logic [3:0] OpNot = 4'd8;
	localparam logic [3:0] OpNeg = 4'd9;
	localparam logic [3:0] OpShl = 4'd10;
	localparam logic [3:0] OpShr = 4'd11;
	localparam logic [3:0] OpAsr = 4'd12;
	localparam logic [3:0] OpRol = 4'd13;
	localparam logic [3:0] OpRor = 4'd14;
	localparam logic [3:0] OpCmp = 4'd15;    // sub, flags only.

	// fixed registers for the RA/RB modes.
	localparam logic [3:0] RegRa = 4'd14;
	localparam logic [3:0] RegRb = 4'd15;

	typedef enum logic [1:0] {
		SrcRegB,          // register b port.
		SrcU4,            // argb zero-extended.
		SrcU8,            // arga:argb zero-extended.
		SrcU8PlusRegB     // register b plus u8.
	} srcB_e;

	typedef struct packed {
		logic z;
		logic n;
		logic c;    // carry out, or borrow on subtract.
		logic v;
	} flags_t;

	typedef struct packed {
		logic [3:0] regAAddr;
		logic [3:0] regBAddr;
		logic [3:0] aluOp;
		srcB_e      srcB;
		logic [7:0] imm8;
		logic       writeA;      // register a write at end of commit.
		logic       flagLoad;    // flag update at end of execute.
	} decodeCtrl_t;

	typedef struct packed {
		logic        written;
		logic [3:0]  regIndex;
		logic [15:0] value;
		flags_t      flags;
	} commit_t;

endpackage

// File: verilog/aluExecute.sv
module aluExecute (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    execute,
	input  aluCorePkg::decodeCtrl_t ctrl,
	input  logic [15:0]             opA,
	input  logic [15:0]             opB,
	output logic [15:0]             result,
	output aluCorePkg::flags_t      flags
);

	logic [15:0]        operandB;     // selected b side.
	logic [15:0]        aluOut;
	logic [16:0]        wide;         // arithmetic with carry out.
	aluCorePkg::flags_t nextFlags;

	// signed overflow rules.
	function automatic logic addOverflow(logic a, logic b, logic r);
		return (a == b) && (r != a);
	endfunction

	function automatic logic subOverflow(logic a, logic b, logic r);
		return (a != b) && (r != a);
	endfunction

	////////////////////////////////////////////////////////////
	// operand b select
	////////////////////////////////////////////////////////////
	always_comb begin : selectB
		case (ctrl.srcB)
			aluCorePkg::SrcU4:         operandB = {12'h000, ctrl.imm8[3:0]};
			aluCorePkg::SrcU8:         operandB = {8'h00, ctrl.imm8};
			aluCorePkg::SrcU8PlusRegB: operandB = opB + {8'h00, ctrl.imm8};
			default:                   operandB = opB;    // register b.
		endcase
	end

	////////////////////////////////////////////////////////////
	// alu and flag generation
	////////////////////////////////////////////////////////////
	always_comb begin : alu
		wide      = '0;
		aluOut    = operandB;
		nextFlags = flags;    // c and v held unless an op sets them.
		case (ctrl.aluOp)
			aluCorePkg::OpMov: begin
				aluOut = operandB;
			end
			aluCorePkg::OpAdd: begin
				wide        = {1'b0, opA} + {1'b0, operandB};
				aluOut      = wide[15:0];
				nextFlags.c = wide[16];
				nextFlags.v = addOverflow(opA[15], operandB[15], aluOut[15]);
			end
			aluCorePkg::OpAdc: begin
				wide        = {1'b0, opA} + {1'b0, operandB} + {16'h0000, flags.c};
				aluOut      = wide[15:0];
				nextFlags.c = wide[16];
				nextFlags.v = addOverflow(opA[15], operandB[15], aluOut[15]);
			end
			aluCorePkg::OpSub, aluCorePkg::OpCmp: begin
				wide        = {1'b0, opA} - {1'b0, operandB};
				aluOut      = wide[15:0];
				nextFlags.c = wide[16];    // borrow.
				nextFlags.v = subOverflow(opA[15], operandB[15], aluOut[15]);
			end
			aluCorePkg::OpSbc: begin
				wide        = {1'b0, opA} - {1'b0, operandB} - {16'h0000, flags.c};
				aluOut      = wide[15:0];
				nextFlags.c = wide[16];
				nextFlags.v = subOverflow(opA[15], operandB[15], aluOut[15]);
			end
			aluCorePkg::OpAnd: begin
				aluOut      = opA & operandB;
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpOr: begin
				aluOut      = opA | operandB;
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpXor: begin
				aluOut      = opA ^ operandB;
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpNot: begin
				aluOut      = ~operandB;
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpNeg: begin
				wide        = 17'h00000 - {1'b0, operandB};    // 0 - b.
				aluOut      = wide[15:0];
				nextFlags.c = wide[16];
				nextFlags.v = subOverflow(1'b0, operandB[15], aluOut[15]);
			end
			aluCorePkg::OpShl: begin
				aluOut      = {opA[14:0], 1'b0};
				nextFlags.c = opA[15];              // bit shifted out.
				nextFlags.v = opA[15] ^ opA[14];    // sign changed.
			end
			aluCorePkg::OpShr: begin
				aluOut      = {1'b0, opA[15:1]};
				nextFlags.c = opA[0];
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpAsr: begin
				aluOut      = {opA[15], opA[15:1]};    // sign kept.
				nextFlags.c = opA[0];
				nextFlags.v = 1'b0;
			end
			aluCorePkg::OpRol: begin
				aluOut      = {opA[14:0], opA[15]};
				nextFlags.c = opA[15];
				nextFlags.v = 1'b0;
			end
			default: begin    // ror.
				aluOut      = {opA[0], opA[15:1]};
				nextFlags.c = opA[0];
				nextFlags.v = 1'b0;
			end
		endcase
		nextFlags.z = (aluOut == 16'h0000);
		nextFlags.n = aluOut[15];
	end

	// result and flags settle at the end of execute.
	always_ff @(posedge CLK) begin : resultReg
		if (execute) begin
			result <= aluOut;
		end
	end

	always_ff @(posedge CLK) begin : flagReg
		if (reset) begin
			flags <= '0;
		end else if (execute && ctrl.flagLoad) begin
			flags <= nextFlags;    // not for mov or no-op groups.
		end
	end

endmodule

// File: verilog/aluGroupDecoder.sv
module aluGroupDecoder (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic [15:0]             instrLatched,
	input  logic                    decode,
	input  logic                    execute,
	input  logic                    commit,
	output logic                    readA,
	output logic                    readB,
	output aluCorePkg::decodeCtrl_t ctrl
);

	logic [1:0] group;
	logic [3:0] aluOp;
	logic [1:0] argf;
	logic [3:0] argA;
	logic [3:0] argB;
	logic       isAlu;       // group 3, everything else is a no-op.
	logic       rdA;
	logic       rdB;
	logic       wrA;
	logic       ldFlags;
	logic       writeAQ;     // held enables, execute through commit.
	logic       flagLoadQ;

	// field split.
	assign group = instrLatched[aluCorePkg::GroupPos +: 2];
	assign aluOp = instrLatched[aluCorePkg::AluOpPos +: 4];
	assign argf  = instrLatched[aluCorePkg::ArgfPos +: 2];
	assign argA  = instrLatched[aluCorePkg::ArgAPos +: 4];
	assign argB  = instrLatched[aluCorePkg::ArgBPos +: 4];

	assign isAlu = (group == aluCorePkg::Group3);

	////////////////////////////////////////////////////////////
	// argument mode decode
	////////////////////////////////////////////////////////////
	always_comb begin : modeDecode
		ctrl          = '0;
		ctrl.regAAddr = argA;              // ra from arga by default.
		ctrl.regBAddr = argB;
		ctrl.aluOp    = aluOp;
		ctrl.srcB     = aluCorePkg::SrcRegB;
		ctrl.imm8     = {argA, argB};      // u8 spans both args.
		rdA           = isAlu;
		rdB           = 1'b0;
		case (argf)
			aluCorePkg::ModeRegReg: begin
				rdB = isAlu;                // second register operand.
			end
			aluCorePkg::ModeRegU4: begin
				ctrl.srcB = aluCorePkg::SrcU4;
			end
			aluCorePkg::ModeRegbU8: begin
				ctrl.regAAddr = aluCorePkg::RegRb;
				ctrl.srcB     = aluCorePkg::SrcU8;
			end
			aluCorePkg::ModeRegaU8Rb: begin
				ctrl.regAAddr = aluCorePkg::RegRa;
				ctrl.regBAddr = aluCorePkg::RegRb;
				ctrl.srcB     = aluCorePkg::SrcU8PlusRegB;
				rdB           = isAlu;      // RB feeds the sum.
			end
			default: begin
				rdB = 1'b0;
			end
		endcase
		ctrl.writeA   = writeAQ;
		ctrl.flagLoad = flagLoadQ;
	end

	// cmp only sets flags, mov leaves them alone.
	assign wrA     = isAlu && (aluOp != aluCorePkg::OpCmp);
	assign ldFlags = isAlu && (aluOp != aluCorePkg::OpMov);

	// read enables live for the decode phase only.
	assign readA = decode && rdA;
	assign readB = decode && rdB;

	////////////////////////////////////////////////////////////
	// phased write and flag enables
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin : enableRegs
		if (reset) begin
			writeAQ   <= 1'b0;
			flagLoadQ <= 1'b0;
		end else if (decode) begin
			writeAQ   <= wrA;        // valid from execute.
			flagLoadQ <= ldFlags;
		end else if (execute || commit) begin
			writeAQ   <= writeAQ & execute;    // kept over execute, dropped after commit.
			flagLoadQ <= flagLoadQ & execute;
		end
	end

endmodule

// File: verilog/phaseSequencer.sv
module phaseSequencer (
	input  logic        CLK,
	input  logic        reset,
	input  logic [15:0] instr,
	input  logic        instrStrobe,
	output logic        ready,
	output logic        fetch,
	output logic        decode,
	output logic        execute,
	output logic        commit,
	output logic [15:0] instrLatched
);

	logic [3:0] phase;    // one-hot, {commit, execute, decode, fetch}.
	logic       accept;   // strobe seen while waiting in fetch.

	assign accept = phase[0] && instrStrobe;

	////////////////////////////////////////////////////////////
	// phase ring
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin : ring
		if (reset) begin
			phase <= 4'b0001;    // park in fetch.
		end else if (!phase[0] || accept) begin
			phase <= {phase[2:0], phase[3]};    // one edge per phase.
		end
	end

	// instruction word, held until the next accepted strobe.
	always_ff @(posedge CLK) begin : instrLatch
		if (accept) begin
			instrLatched <= instr;
		end
	end

	assign fetch   = phase[0];
	assign decode  = phase[1];
	assign execute = phase[2];
	assign commit  = phase[3];
	assign ready   = phase[0];    // strobes only count in fetch.

endmodule

// File: verilog/registerFile.sv
module registerFile (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    decode,
	input  logic                    commit,
	input  logic                    readA,
	input  logic                    readB,
	input  aluCorePkg::decodeCtrl_t ctrl,
	input  logic [15:0]             result,
	output logic [15:0]             opA,
	output logic [15:0]             opB
);

	logic [15:0] regs [aluCorePkg::RegCount];

	////////////////////////////////////////////////////////////
	// write-back
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin : writeBack
		if (reset) begin
			for (int i = 0; i < aluCorePkg::RegCount; i++) begin
				regs[i] <= '0;    // all registers start at zero.
			end
		end else if (commit && ctrl.writeA) begin
			regs[ctrl.regAAddr] <= result;    // edge that ends commit.
		end
	end

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////
	// captured at the end of decode, operands good in execute.
	always_ff @(posedge CLK) begin : readPortA
		if (decode && readA) begin
			opA <= regs[ctrl.regAAddr];
		end
	end

	always_ff @(posedge CLK) begin : readPortB
		if (decode && readB) begin
			opB <= regs[ctrl.regBAddr];    // stale when the mode has no rb.
		end
	end

endmodule
